// File: compile.f
design/fir_pkg.sv
design/fir_control.sv
design/fir_datapath.sv
design/fir_output_stage.sv
design/fir_filter.sv
test/tb_clock.sv
test/fir_filter_chk.sv
test/fir_filter_tb.sv

// File: Makefile
# Verilator build and run for the FIR filter testbench.
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fir_filter_tb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All checks passed

.PHONY: sim clean

# Build, run, then decide pass or fail from the log.
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: test/fir_filter_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fir_filter_tb import fir_pkg::*; ();

	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 4;
	localparam int STREAM_LEN = 40;
	localparam int GAP_SAMPLES = 25;
	localparam int MAX_GAP = 3;

	// Cycle budget of the whole run with one term per test and a margin.
	localparam int RUN_CYCLES = RESET_CYCLES + (2 * TAPS + 2) + (TAPS + STREAM_LEN + 2)
		+ (TAPS + GAP_SAMPLES * (MAX_GAP + 1) + 2) + 2 * (2 * TAPS + 4)
		+ (2 * TAPS + 30) + (2 * TAPS + 25);
	localparam int TIMEOUT_CYCLES = RUN_CYCLES + 100;

	logic clock;
	logic rst;
	logic load_coefficients;
	sample_t coefficient_in;
	logic sample_strobe;
	sample_t sample_in;
	logic stop;
	logic running;
	fir_out_t data_out;
	logic out_valid;

	logic [31:0] rng_state;
	string test_name;
	int check_count;
	int error_count;
	int test_errors;
	int coef_set [TAPS];

	// Reference model of the filter as seen at its ports.
	fir_state_t m_state;
	int m_cnt;
	int m_coef [TAPS];
	int m_line [TAPS];
	int m_sum;
	logic m_sum_valid;
	logic m_out_valid;
	int m_data_out;

	tb_clock #(.PERIOD_NS(CLOCK_PERIOD)) i_clock (.clock(clock));

	fir_filter i_dut (
		.clock             (clock),
		.rst               (rst),
		.load_coefficients (load_coefficients),
		.coefficient_in    (coefficient_in),
		.sample_strobe     (sample_strobe),
		.sample_in         (sample_in),
		.stop              (stop),
		.running           (running),
		.data_out          (data_out),
		.out_valid         (out_valid)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Clamp a full-precision sum to the signed output range.
	function automatic int clamp_output(input int value);
		if (value > OUT_MAX) begin
			return OUT_MAX;
		end
		if (value < OUT_MIN) begin
			return OUT_MIN;
		end
		return value;
	endfunction

	task automatic random_sample(output sample_t value);
		rng_state = xorshift32(rng_state);
		value = sample_t'(rng_state[7:0]);
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		check_count++;
		if (expected != actual) begin
			error_count++;
			test_errors++;
			$display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, expected,
				actual);
		end
	endtask

	// Advance the model by one rising edge with the inputs that the DUT saw.
	task automatic model_edge();
		int acc;
		if (rst) begin
			m_state = ST_IDLE;
			m_cnt = 0;
			m_sum_valid = 1'b0;
			m_out_valid = 1'b0;
			m_data_out = 0;
			foreach (m_coef[k]) begin
				m_coef[k] = 0;
				m_line[k] = 0;
			end
			return;
		end
		// The output stage takes the sum registered on the previous edge.
		m_out_valid = m_sum_valid;
		if (m_sum_valid) begin
			m_data_out = clamp_output(m_sum);
		end
		// A strobe counts only in the run state, and the new sample joins the sum.
		m_sum_valid = sample_strobe && (m_state == ST_RUN);
		if (m_sum_valid) begin
			for (int k = TAPS - 1; k > 0; k--) begin
				m_line[k] = m_line[k-1];
			end
			m_line[0] = int'(sample_in);
			acc = 0;
			for (int k = 0; k < TAPS; k++) begin
				acc += m_coef[k] * m_line[k];
			end
			m_sum = acc;
		end
		if (m_state == ST_LOAD) begin
			m_coef[m_cnt] = int'(coefficient_in);
			if (m_cnt == TAPS - 1) begin
				m_state = ST_RUN;
			end
			m_cnt++;
		end else if (load_coefficients) begin
			// A reload starts from an empty history.
			m_coef[0] = int'(coefficient_in);
			m_cnt = 1;
			m_state = ST_LOAD;
			foreach (m_line[k]) begin
				m_line[k] = 0;
			end
		end else if (m_state == ST_RUN && stop) begin
			m_state = ST_STOP;
		end
	endtask

	// Drive one cycle from a falling edge, then compare the ports at the next one.
	task automatic drive_cycle(input logic strobe, input sample_t smp, input logic stp,
		input logic load, input sample_t coef);
		sample_strobe = strobe;
		sample_in = smp;
		stop = stp;
		load_coefficients = load;
		coefficient_in = coef;
		@(posedge clock);
		model_edge();
		@(negedge clock);
		check_value("running", (m_state == ST_RUN) ? 1 : 0, int'(running));
		check_value("out_valid", int'(m_out_valid), int'(out_valid));
		check_value("data_out", m_data_out, int'(data_out));
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, '0, 1'b0, 1'b0, '0);
	endtask

	task automatic strobe_random();
		sample_t s;
		random_sample(s);
		drive_cycle(1'b1, s, 1'b0, 1'b0, '0);
	endtask

	task automatic fill_random_coefs();
		sample_t c;
		for (int k = 0; k < TAPS; k++) begin
			random_sample(c);
			coef_set[k] = int'(c);
		end
	endtask

	// Send one load pulse with coefficient 0 and then the rest of the burst.
	task automatic load_coef_set();
		for (int k = 0; k < TAPS; k++) begin
			drive_cycle(1'b0, '0, 1'b0, (k == 0), sample_t'(coef_set[k]));
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		$display("%s finished with %0d mismatches", test_name, test_errors);
	endtask

	task automatic impulse_response();
		start_test("impulse_response");
		fill_random_coefs();
		for (int k = 0; k < TAPS; k++) begin
			drive_cycle(1'b0, '0, 1'b0, (k == 0), sample_t'(coef_set[k]));
			// Running rises on the edge that stores the last coefficient.
			check_value("running during load", (k == TAPS - 1) ? 1 : 0, int'(running));
		end
		// A single 1 walks through the line and reads out each tap in turn.
		for (int j = 0; j <= TAPS; j++) begin
			drive_cycle((j < TAPS), sample_t'((j == 0) ? 1 : 0), 1'b0, 1'b0, '0);
			if (j >= 1) begin
				check_value("impulse tap", coef_set[j-1], int'(data_out));
			end
		end
		idle_cycle();
		end_test();
	endtask

	task automatic continuous_stream();
		start_test("continuous_stream");
		fill_random_coefs();
		load_coef_set();
		repeat (STREAM_LEN) strobe_random();
		repeat (2) idle_cycle();
		end_test();
	endtask

	task automatic gapped_strobes();
		int gap;
		start_test("gapped_strobes");
		fill_random_coefs();
		load_coef_set();
		for (int n = 0; n < GAP_SAMPLES; n++) begin
			strobe_random();
			rng_state = xorshift32(rng_state);
			gap = int'(rng_state[1:0]);
			// Between pulses data_out must keep the last result.
			repeat (gap) idle_cycle();
		end
		repeat (2) idle_cycle();
		end_test();
	endtask

	task automatic saturate_with(input int coef, input int smp);
		foreach (coef_set[k]) begin
			coef_set[k] = coef;
		end
		load_coef_set();
		repeat (TAPS + 2) drive_cycle(1'b1, sample_t'(smp), 1'b0, 1'b0, '0);
		repeat (2) idle_cycle();
		// With a full line every tap sees the same product.
		check_value("full line", clamp_output(TAPS * coef * smp), int'(data_out));
	endtask

	task automatic saturation_limits();
		start_test("saturation_limits");
		saturate_with(-128, -128);
		saturate_with(127, -128);
		end_test();
	endtask

	task automatic stop_and_reload();
		sample_t s;
		start_test("stop_and_reload");
		fill_random_coefs();
		load_coef_set();
		repeat (8) strobe_random();
		// A strobe that lands with the stop pulse is still taken.
		random_sample(s);
		drive_cycle(1'b1, s, 1'b1, 1'b0, '0);
		repeat (2) idle_cycle();
		for (int n = 0; n < 5; n++) begin
			strobe_random();
			check_value("out_valid while stopped", 0, int'(out_valid));
			check_value("running while stopped", 0, int'(running));
		end
		fill_random_coefs();
		load_coef_set();
		repeat (12) strobe_random();
		repeat (2) idle_cycle();
		end_test();
	endtask

	task automatic reset_mid_run();
		start_test("reset_mid_run");
		fill_random_coefs();
		load_coef_set();
		repeat (6) strobe_random();
		rst = 1'b1;
		repeat (4) strobe_random();
		rst = 1'b0;
		check_value("running after reset", 0, int'(running));
		check_value("out_valid after reset", 0, int'(out_valid));
		// Without a new load the filter stays idle and drops every strobe.
		for (int n = 0; n < 6; n++) begin
			strobe_random();
			check_value("out_valid before load", 0, int'(out_valid));
		end
		fill_random_coefs();
		load_coef_set();
		repeat (5) strobe_random();
		repeat (2) idle_cycle();
		end_test();
	endtask

	// Watchdog sized from the cycle budget of all tests.
	initial begin
		#(TIMEOUT_CYCLES * CLOCK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial begin
		rng_state = 32'he0e4_94d3;
		check_count = 0;
		error_count = 0;
		test_errors = 0;
		test_name = "reset";
		rst = 1'b1;
		load_coefficients = 1'b0;
		coefficient_in = '0;
		sample_strobe = 1'b0;
		sample_in = '0;
		stop = 1'b0;
		repeat (RESET_CYCLES) idle_cycle();
		rst = 1'b0;
		impulse_response();
		continuous_stream();
		gapped_strobes();
		saturation_limits();
		stop_and_reload();
		reset_mid_run();
		$display("Summary: 6 tests, %0d checks, %0d mismatches", check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/fir_filter_chk.sv
`timescale 1ns/100ps
`default_nettype none

module fir_filter_chk (
	input logic clock,
	input logic rst,
	input logic sum_valid,
	input logic line_clear,
	input logic running,
	input logic out_valid
);

	// A result leaves the output stage one edge after its sum was registered.
	a_out_after_sum: assert property (@(posedge clock) disable iff (rst)
		out_valid |-> $past(sum_valid))
		else $error("out_valid seen without sum_valid one cycle earlier");

	// The delay-line clear is a single-cycle pulse.
	a_clear_pulse: assert property (@(posedge clock) disable iff (rst)
		line_clear |=> !line_clear)
		else $error("line_clear held high for more than one cycle");

	// Any edge taken in reset leaves the filter out of the run state.
	a_reset_stops: assert property (@(posedge clock)
		$past(rst) |-> !running)
		else $error("running high after a reset edge");

endmodule

// Attach the checker to every instance of the filter top level.
bind fir_filter fir_filter_chk i_chk (
	.clock      (clock),
	.rst        (rst),
	.sum_valid  (sum_valid),
	.line_clear (line_clear),
	.running    (running),
	.out_valid  (out_valid)
);

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 40
) (
	output logic clock
);

	// Free-running clock that stays low for the first half period.
	initial begin
		clock = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			clock = ~clock;
		end
	end

endmodule

`default_nettype wire

// File: design/fir_filter.sv
`timescale 1ns/100ps
`default_nettype none

module fir_filter import fir_pkg::*; (
	input  logic     clock,
	input  logic     rst,
	input  logic     load_coefficients,
	input  sample_t  coefficient_in,
	input  logic     sample_strobe,
	input  sample_t  sample_in,
	input  logic     stop,
	output logic     running,
	output fir_out_t data_out,
	output logic     out_valid
);

	// Coefficients as stored by the control block.
	coeff_bank_t coeff_bank;

	// One-cycle pulse that empties the delay line on a reload.
	logic line_clear;

	// Full-precision sum and its valid flag that arrive one edge after acceptance.
	acc_t sum;
	logic sum_valid;

	// Control block.
	// Holds the state, the coefficient burst logic and the bank.
	fir_control i_control (
		.clock             (clock),
		.rst               (rst),
		.load_coefficients (load_coefficients),
		.coefficient_in    (coefficient_in),
		.stop              (stop),
		.coeff_bank        (coeff_bank),
		.running           (running),
		.line_clear        (line_clear)
	);

	// Datapath.
	// Keeps the sample history and forms the sum of products.
	fir_datapath i_datapath (
		.clock         (clock),
		.rst           (rst),
		.sample_strobe (sample_strobe),
		.sample_in     (sample_in),
		.running       (running),
		.line_clear    (line_clear),
		.coeff_bank    (coeff_bank),
		.sum           (sum),
		.sum_valid     (sum_valid)
	);

	// Output stage.
	// Clamps the sum to the output width and registers it.
	fir_output_stage i_output_stage (
		.clock     (clock),
		.rst       (rst),
		.sum       (sum),
		.sum_valid (sum_valid),
		.data_out  (data_out),
		.out_valid (out_valid)
	);

endmodule

`default_nettype wire

// File: design/fir_output_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fir_output_stage import fir_pkg::*; (
	input  logic     clock,
	input  logic     rst,
	input  acc_t     sum,
	input  logic     sum_valid,
	output fir_out_t data_out,
	output logic     out_valid
);

	// Sum after clamping to the output range.
	fir_out_t sat_value;

	// Anything outside the signed output range is pinned to the nearest limit.
	// Inside the range the upper bits are copies of the sign and can be dropped.
	always_comb begin
		if (sum > acc_t'(OUT_MAX)) begin
			sat_value = fir_out_t'(OUT_MAX);
		end else if (sum < acc_t'(OUT_MIN)) begin
			sat_value = fir_out_t'(OUT_MIN);
		end else begin
			sat_value = fir_out_t'(sum);
		end
	end

	// Output register.
	// data_out keeps the last result until the next valid sum arrives.
	always_ff @(posedge clock) begin
		if (rst) begin
			data_out <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= sum_valid;
			if (sum_valid) begin
				data_out <= sat_value;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/fir_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module fir_datapath import fir_pkg::*; (
	input  logic        clock,
	input  logic        rst,
	input  logic        sample_strobe,
	input  sample_t     sample_in,
	input  logic        running,
	input  logic        line_clear,
	input  coeff_bank_t coeff_bank,
	output acc_t        sum,
	output logic        sum_valid
);

	// Delay line with the newest sample at index 0.
	sample_t [TAPS-1:0] line_q;

	// The line as it will look after the current strobe is shifted in.
	sample_t [TAPS-1:0] line_next;

	// One product per tap and their full-precision total.
	acc_t products [TAPS];
	acc_t sum_next;

	// A sample only counts while the control block is in the run state.
	logic accept;

	assign accept = sample_strobe && running;

	// Shifted view of the line.
	// The sum is taken over this view so that the new sample is included
	// in the result registered on the same edge.
	always_comb begin
		line_next[0] = sample_in;
		for (int k = 1; k < TAPS; k++) begin
			line_next[k] = line_q[k-1];
		end
	end

	// Ten signed multiplies with both operands widened to the sum width first.
	for (genvar k = 0; k < TAPS; k++) begin : g_tap
		assign products[k] = acc_t'($signed(coeff_bank[k])) * acc_t'($signed(line_next[k]));
	end

	// Adder over all taps.
	always_comb begin
		sum_next = '0;
		for (int k = 0; k < TAPS; k++) begin
			sum_next = sum_next + products[k];
		end
	end

	// Delay line and valid flag.
	// A clear from the control block wipes the history before a new run.
	always_ff @(posedge clock) begin
		if (rst || line_clear) begin
			line_q <= '0;
		end else if (accept) begin
			line_q <= line_next;
		end
		if (rst) begin
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= accept;
		end
	end

	// Registered sum that only updates for an accepted sample.
	always_ff @(posedge clock) begin
		if (accept) begin
			sum <= sum_next;
		end
	end

endmodule

`default_nettype wire

// File: design/fir_control.sv
`timescale 1ns/100ps
`default_nettype none

module fir_control import fir_pkg::*; (
	input  logic        clock,
	input  logic        rst,
	input  logic        load_coefficients,
	input  sample_t     coefficient_in,
	input  logic        stop,
	output coeff_bank_t coeff_bank,
	output logic        running,
	output logic        line_clear
);

	// Current and next filter state.
	fir_state_t state;
	fir_state_t state_next;

	// Slot of the bank that the next coefficient of a burst goes to.
	logic [TAP_CNT_WIDTH-1:0] tap_cnt;

	// A load pulse counts in every state except during a burst.
	logic load_accept;

	// High on the edge that stores the final coefficient of a burst.
	logic last_tap;

	assign load_accept = load_coefficients && (state != ST_LOAD);
	assign last_tap = (state == ST_LOAD) && (tap_cnt == TAP_CNT_WIDTH'(TAP_LAST));

	// Samples are only taken while the filter sits in the run state.
	assign running = (state == ST_RUN);

	// Next-state logic.
	// A honoured load pulse always wins, so a stopped or running filter
	// can be given a fresh set of coefficients.
	always_comb begin
		state_next = state;
		case (state)
			ST_LOAD: begin
				// Strobe and stop are ignored until the burst is complete.
				if (last_tap) begin
					state_next = ST_RUN;
				end
			end
			ST_RUN: begin
				if (load_accept) begin
					state_next = ST_LOAD;
				end else if (stop) begin
					state_next = ST_STOP;
				end
			end
			ST_IDLE, ST_STOP: begin
				if (load_accept) begin
					state_next = ST_LOAD;
				end
			end
		endcase
	end

	// State register, tap counter and the one-cycle clear pulse.
	always_ff @(posedge clock) begin
		if (rst) begin
			state <= ST_IDLE;
			tap_cnt <= '0;
			line_clear <= 1'b0;
		end else begin
			state <= state_next;
			// The clear pulse follows the load pulse by one edge and zeroes
			// the delay line while the burst is still being stored.
			line_clear <= load_accept;
			if (load_accept) begin
				// Coefficient 0 is taken on the load edge itself.
				tap_cnt <= TAP_CNT_WIDTH'(1);
			end else if (state == ST_LOAD) begin
				tap_cnt <= tap_cnt + 1'b1;
			end
		end
	end

	// Coefficient bank.
	// Each coefficient lands in the slot given by its position in the burst.
	always_ff @(posedge clock) begin
		if (rst) begin
			coeff_bank <= '0;
		end else if (load_accept) begin
			coeff_bank[0] <= coefficient_in;
		end else if (state == ST_LOAD) begin
			coeff_bank[tap_cnt] <= coefficient_in;
		end
	end

endmodule

`default_nettype wire

// File: design/fir_pkg.sv
`default_nettype none

package fir_pkg;

	// Number of taps in the filter and the width of one sample or coefficient.
	localparam int TAPS = 10;
	localparam int DATA_WIDTH = 8;

	// Width of the tap counter and the index of the last tap.
	localparam int TAP_CNT_WIDTH = $clog2(TAPS);
	localparam int TAP_LAST = TAPS - 1;

	// A full-precision sum needs two data widths for the product and
	// enough extra bits to hold TAPS products added together.
	localparam int ACC_WIDTH = 2 * DATA_WIDTH + TAP_CNT_WIDTH;

	// Width of the registered output word.
	localparam int OUT_WIDTH = 19;

	// Signed limits of the output word for the saturation logic.
	localparam int OUT_MAX = (1 << (OUT_WIDTH - 1)) - 1;
	localparam int OUT_MIN = -(1 << (OUT_WIDTH - 1));

	// One signed word that serves for samples and coefficients.
	typedef logic signed [DATA_WIDTH-1:0] sample_t;

	// Index k holds the k-th coefficient loaded after a load pulse.
	typedef sample_t [TAPS-1:0] coeff_bank_t;

	typedef logic signed [ACC_WIDTH-1:0] acc_t;
	typedef logic signed [OUT_WIDTH-1:0] fir_out_t;

	// Filter states.
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_RUN,
		ST_STOP
	} fir_state_t;

endpackage

`default_nettype wire
